// File: rtl/elevator_pkg.sv
package elevator_pkg;

    ////////////////////////////////////////
    // floors
    ////////////////////////////////////////

    localparam int NUM_FLOORS = 16;    // floors 0..15

    typedef logic [3:0] floor_t;       // one floor number

    // reset parking spots
    localparam floor_t CAR0_HOME = 4'd0; // even car
    localparam floor_t CAR1_HOME = 4'd1; // odd car

    ////////////////////////////////////////
    // motor
    ////////////////////////////////////////

    // motor state seen on the car outputs
    typedef enum logic [1:0] {
        STOP = 2'd0,                   // parked or dwelling
        UP   = 2'd1,
        DOWN = 2'd2
    } motion_t;

    ////////////////////////////////////////
    // display
    ////////////////////////////////////////

    // one digit as {a,b,c,d,e,f,g}
    // active low, 0 lights the segment
    typedef logic [6:0] seg_t;

endpackage

// File: rtl/tick_gen.sv
`timescale 1ns/1ps

module tick_gen #(
    parameter int PERIOD = 4           // cycles between ticks
) (
    input  logic clk,
    input  logic reset,
    output logic tick                  // one cycle wide
);

    localparam int CNT_W = (PERIOD > 1) ? $clog2(PERIOD) : 1;

    logic [CNT_W-1:0] cnt;             // counts down to zero

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt  <= CNT_W'(PERIOD - 1);
            tick <= 1'b0;              // quiet out of reset
        end else if (cnt == '0) begin
            cnt  <= CNT_W'(PERIOD - 1); // wrap and reload
            tick <= 1'b1;
        end else begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

    // a period of 2 or more keeps ticks apart
    a_tick_gap: assert property (@(posedge clk) disable iff (reset) tick |=> !tick)
        else $error("tick_gen: back to back ticks, PERIOD %0d", PERIOD);

endmodule

// File: rtl/request_dispatch.sv
`timescale 1ns/1ps

module request_dispatch import elevator_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   req_valid,
    input  floor_t req_floor,
    input  logic   car0_credit_return,
    input  logic   car1_credit_return,
    output logic   req_ready,
    output logic   car0_target_valid,
    output floor_t car0_target_floor,
    output logic   car1_target_valid,
    output floor_t car1_target_floor
);

    logic         car_sel;             // 0 even car, 1 odd car
    logic   [1:0] credit;              // bit n set, car n is free
    logic   [1:0] credit_ret;          // returns from the cars
    logic   [1:0] take;                // accepted this cycle, one hot
    logic   [1:0] tgt_valid;           // target pulse per car
    floor_t       tgt_floor [2];       // target per car

    ////////////////////////////////////////
    // acceptance
    ////////////////////////////////////////

    assign car_sel    = req_floor[0];  // floor parity picks the car
    assign credit_ret = {car1_credit_return, car0_credit_return};

    // ready follows the credit of the car that owns the floor
    assign req_ready = credit[car_sel];

    assign take[0] = req_valid && req_ready && !car_sel;
    assign take[1] = req_valid && req_ready && car_sel;

    ////////////////////////////////////////
    // credits and target pulses
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credit    <= 2'b11;        // both cars start free
            tgt_valid <= 2'b00;
        end else begin
            tgt_valid <= take;         // one cycle after acceptance
            // spend on accept, restore on return
            credit    <= (credit & ~take) | credit_ret;
        end
    end

    // payload only, loaded with the pulse
    always_ff @(posedge clk) begin
        for (int n = 0; n < 2; n++) begin
            if (take[n]) begin
                tgt_floor[n] <= req_floor;
            end
        end
    end

    assign car0_target_valid = tgt_valid[0];
    assign car0_target_floor = tgt_floor[0];
    assign car1_target_valid = tgt_valid[1];
    assign car1_target_floor = tgt_floor[1];

    // a car gives back only the credit it was handed
    a_credit_once: assert property (@(posedge clk) disable iff (reset)
        (credit_ret & credit) == 2'b00)
        else $error("request_dispatch: credit return %b with credit %b held",
                    credit_ret, credit);

endmodule

// File: rtl/car_controller.sv
`timescale 1ns/1ps

module car_controller import elevator_pkg::*; #(
    parameter floor_t HOME_FLOOR = CAR0_HOME // floor after reset
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    move_tick,         // one floor per tick
    input  logic    dwell_tick,        // ends the stop at a floor
    input  logic    target_valid,
    input  floor_t  target_floor,
    output floor_t  floor,
    output motion_t motion,
    output logic    credit_return
);

    // car phase kept apart from the motor code
    typedef enum logic [1:0] {
        IDLE,                          // free for a new target
        MOVING,                        // stepping toward target
        DWELLING                       // doors open until the dwell tick
    } phase_t;

    phase_t phase;
    floor_t target;                    // latched destination
    floor_t next_floor;                // one step in current direction
    logic   arrive;                    // next step lands on the target

    ////////////////////////////////////////
    // step logic
    ////////////////////////////////////////

    assign next_floor = (motion == UP) ? floor + 4'd1 : floor - 4'd1;
    assign arrive     = (next_floor == target);

    // credit goes back on the first dwell tick after arrival
    assign credit_return = (phase == DWELLING) && dwell_tick;

    ////////////////////////////////////////
    // phase and motor FSM
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase  <= IDLE;
            floor  <= HOME_FLOOR;
            motion <= STOP;
        end else begin
            case (phase)
                IDLE: begin
                    if (target_valid) begin
                        if (target_floor > floor) begin
                            motion <= UP;
                            phase  <= MOVING;
                        end else if (target_floor < floor) begin
                            motion <= DOWN;
                            phase  <= MOVING;
                        end else begin
                            phase  <= DWELLING; // already there so only dwell
                        end
                    end
                end
                MOVING: begin
                    if (move_tick) begin
                        floor <= next_floor;
                        if (arrive) begin
                            motion <= STOP; // stops with the last step
                            phase  <= DWELLING;
                        end
                    end
                end
                DWELLING: begin
                    if (dwell_tick) begin
                        phase <= IDLE;
                    end
                end
                default: begin
                    phase  <= IDLE;
                    motion <= STOP;
                end
            endcase
        end
    end

    // destination taken with the target pulse
    always_ff @(posedge clk) begin
        if (target_valid && (phase == IDLE)) begin
            target <= target_floor;
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // dispatcher credit keeps one target per trip
    a_target_idle: assert property (@(posedge clk) disable iff (reset)
        target_valid |-> (phase == IDLE))
        else $error("car_controller: target while busy, phase %s", phase.name());

    // floor moves one step at a time and never wraps
    a_floor_step: assert property (@(posedge clk) disable iff (reset)
        $changed(floor) |-> ((int'(floor) - int'($past(floor)) == 1)
            || (int'($past(floor)) - int'(floor) == 1)))
        else $error("car_controller: floor jumped to %0d", floor);

    // a moving car always has a floor left in its direction
    a_floor_range: assert property (@(posedge clk) disable iff (reset)
        (phase == MOVING) |-> ((motion == UP) ? (int'(floor) < NUM_FLOORS - 1)
                                              : (floor != '0)))
        else $error("car_controller: moving %s from floor %0d", motion.name(), floor);

endmodule

// File: rtl/floor_display.sv
`timescale 1ns/1ps

module floor_display import elevator_pkg::*; (
    input  floor_t floor,
    output seg_t   seg_tens,           // blank or "1"
    output seg_t   seg_ones
);

    localparam seg_t SEG_BLANK = 7'b111_1111; // all segments dark

    logic       tens;                  // floor 10 and up
    logic [3:0] ones;                  // low decimal digit

    // digit to segments, a..g, active low
    function automatic seg_t digit_seg(input logic [3:0] d);
        case (d)
            4'd0:    return 7'b000_0001;
            4'd1:    return 7'b100_1111;
            4'd2:    return 7'b001_0010;
            4'd3:    return 7'b000_0110;
            4'd4:    return 7'b100_1100;
            4'd5:    return 7'b010_0100;
            4'd6:    return 7'b010_0000;
            4'd7:    return 7'b000_1111;
            4'd8:    return 7'b000_0000;
            4'd9:    return 7'b000_0100;
            default: return SEG_BLANK; // not a decimal digit
        endcase
    endfunction

    ////////////////////////////////////////
    // split into decimal digits
    ////////////////////////////////////////

    assign tens = (floor >= 4'd10);
    assign ones = tens ? floor - 4'd10 : floor;

    assign seg_tens = tens ? digit_seg(4'd1) : SEG_BLANK;
    assign seg_ones = digit_seg(ones);

endmodule

// File: rtl/elevator_top.sv
`timescale 1ns/1ps

module elevator_top import elevator_pkg::*; #(
    parameter int DWELL_PERIOD     = 8, // stop time at a floor
    parameter int CAR0_MOVE_PERIOD = 4, // car 0 speed, cycles per floor
    parameter int CAR1_MOVE_PERIOD = 6  // car 1 runs slower
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    req_valid,
    input  floor_t  req_floor,
    output logic    req_ready,
    output floor_t  car0_floor,
    output floor_t  car1_floor,
    output motion_t car0_motion,
    output motion_t car1_motion,
    output seg_t    car0_seg_tens,
    output seg_t    car0_seg_ones,
    output seg_t    car1_seg_tens,
    output seg_t    car1_seg_ones
);

    logic   dwell_tick;                // shared by both cars
    logic   car0_move_tick;
    logic   car1_move_tick;
    logic   car0_target_valid;
    logic   car1_target_valid;
    floor_t car0_target_floor;
    floor_t car1_target_floor;
    logic   car0_credit_return;
    logic   car1_credit_return;

    ////////////////////////////////////////
    // tick enables
    ////////////////////////////////////////

    tick_gen #(.PERIOD(DWELL_PERIOD)) i_dwell_tick (
        .clk   (clk),
        .reset (reset),
        .tick  (dwell_tick)
    );

    tick_gen #(.PERIOD(CAR0_MOVE_PERIOD)) i_car0_move_tick (
        .clk   (clk),
        .reset (reset),
        .tick  (car0_move_tick)
    );

    tick_gen #(.PERIOD(CAR1_MOVE_PERIOD)) i_car1_move_tick (
        .clk   (clk),
        .reset (reset),
        .tick  (car1_move_tick)
    );

    ////////////////////////////////////////
    // request split, even/odd
    ////////////////////////////////////////

    request_dispatch i_dispatch (
        .clk                (clk),
        .reset              (reset),
        .req_valid          (req_valid),
        .req_floor          (req_floor),
        .car0_credit_return (car0_credit_return),
        .car1_credit_return (car1_credit_return),
        .req_ready          (req_ready),
        .car0_target_valid  (car0_target_valid),
        .car0_target_floor  (car0_target_floor),
        .car1_target_valid  (car1_target_valid),
        .car1_target_floor  (car1_target_floor)
    );

    ////////////////////////////////////////
    // cars
    ////////////////////////////////////////

    car_controller #(.HOME_FLOOR(CAR0_HOME)) i_car0 (
        .clk           (clk),
        .reset         (reset),
        .move_tick     (car0_move_tick),
        .dwell_tick    (dwell_tick),
        .target_valid  (car0_target_valid),
        .target_floor  (car0_target_floor),
        .floor         (car0_floor),
        .motion        (car0_motion),
        .credit_return (car0_credit_return)
    );

    car_controller #(.HOME_FLOOR(CAR1_HOME)) i_car1 (
        .clk           (clk),
        .reset         (reset),
        .move_tick     (car1_move_tick),
        .dwell_tick    (dwell_tick),
        .target_valid  (car1_target_valid),
        .target_floor  (car1_target_floor),
        .floor         (car1_floor),
        .motion        (car1_motion),
        .credit_return (car1_credit_return)
    );

    // each display follows its own car
    floor_display i_car0_display (
        .floor    (car0_floor),
        .seg_tens (car0_seg_tens),
        .seg_ones (car0_seg_ones)
    );

    floor_display i_car1_display (
        .floor    (car1_floor),
        .seg_tens (car1_seg_tens),
        .seg_ones (car1_seg_ones)
    );

endmodule

// File: verification/elevator_tb.sv
`timescale 1ns/1ps

module elevator_tb import elevator_pkg::*; ();

    localparam int CLK_PERIOD  = 40;   // ns
    localparam int DWELL       = 8;
    localparam int CAR0_MOVE   = 4;
    localparam int CAR1_MOVE   = 6;
    localparam int MAX_MOVE    = (CAR0_MOVE > CAR1_MOVE) ? CAR0_MOVE : CAR1_MOVE;
    localparam int MAX_PERIOD  = (DWELL > MAX_MOVE) ? DWELL : MAX_MOVE; // largest of the three
    localparam int NUM_TESTS   = 6;
    localparam int TRIP_LIMIT  = NUM_FLOORS * MAX_PERIOD * 2; // cycles per wait
    localparam int WATCHDOG_CYCLES = NUM_TESTS * NUM_FLOORS * MAX_PERIOD * 4;

    localparam seg_t SEG_OFF = 7'b111_1111;
    // reference digits a..g in active low
    localparam seg_t DIGIT_SEG [10] = '{
        7'b000_0001, 7'b100_1111, 7'b001_0010, 7'b000_0110, 7'b100_1100,
        7'b010_0100, 7'b010_0000, 7'b000_1111, 7'b000_0000, 7'b000_0100
    };

    logic    clk;
    logic    reset;
    logic    req_valid;
    floor_t  req_floor;
    logic    req_ready;
    floor_t  car0_floor, car1_floor;
    motion_t car0_motion, car1_motion;
    seg_t    car0_seg_tens, car0_seg_ones, car1_seg_tens, car1_seg_ones;

    string       test_name;
    int          error_count  = 0;
    int          tests_failed = 0;
    int          errors_at_start;
    logic [31:0] rng_state    = 32'hc080;

    elevator_top #(
        .DWELL_PERIOD     (DWELL),
        .CAR0_MOVE_PERIOD (CAR0_MOVE),
        .CAR1_MOVE_PERIOD (CAR1_MOVE)
    ) i_dut (
        .clk (clk), .reset (reset),
        .req_valid (req_valid), .req_floor (req_floor), .req_ready (req_ready),
        .car0_floor (car0_floor), .car1_floor (car1_floor),
        .car0_motion (car0_motion), .car1_motion (car1_motion),
        .car0_seg_tens (car0_seg_tens), .car0_seg_ones (car0_seg_ones),
        .car1_seg_tens (car1_seg_tens), .car1_seg_ones (car1_seg_ones)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // helpers and compares
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic floor_t car_floor(input int car);
        return car ? car1_floor : car0_floor;
    endfunction

    function automatic motion_t car_motion(input int car);
        return car ? car1_motion : car0_motion;
    endfunction

    task automatic flag_error(input string msg);
        $display("%s: %s", test_name, msg);
        error_count++;
    endtask

    task automatic compare_floor(input string what, input floor_t expected, input floor_t actual);
        if (actual !== expected) begin
            $display("FAIL %s %s: expected %0d actual %0d", test_name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic compare_motion(input string what, input motion_t expected,
                                  input motion_t actual);
        if (actual !== expected) begin
            $display("FAIL %s %s: expected %s actual %0d", test_name, what,
                     expected.name(), actual);
            error_count++;
        end
    endtask

    task automatic compare_seg(input string what, input seg_t expected, input seg_t actual);
        if (actual !== expected) begin
            $display("FAIL %s %s: expected %b actual %b", test_name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic compare_ready(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL %s %s: expected %b actual %b", test_name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic next_cycle();       // drive point 2 ns after the edge
        @(posedge clk);
        #2;
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
    endtask

    task automatic end_test();
        if (error_count == errors_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, error_count - errors_at_start);
            tests_failed++;
        end
    endtask

    // present a request and hold it until accepted
    task automatic send_request(input floor_t dest, output int waited);
        req_floor = dest;
        req_valid = 1'b1;
        waited    = 0;
        @(negedge clk);
        while (!req_ready && waited < TRIP_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!req_ready) flag_error($sformatf("request for floor %0d never accepted", dest));
        next_cycle();                  // taken on this edge
        req_valid = 1'b0;
    endtask

    // watch one parity until its credit is back
    task automatic wait_ready(input floor_t parity_floor);
        int cycles;
        cycles    = 0;
        req_floor = parity_floor;
        @(negedge clk);
        while (!req_ready && cycles < TRIP_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!req_ready) flag_error($sformatf("no credit back for floor %0d", parity_floor));
        next_cycle();
    endtask

    // one trip of one car while the other stays parked
    task automatic trip(input int car, input floor_t dest, output bit saw_up, output bit saw_down);
        floor_t  start, prev, cur, other, step;
        motion_t dir;
        int      waited, cycles;
        start    = car_floor(car);
        other    = car_floor(1 - car);
        saw_up   = 1'b0;
        saw_down = 1'b0;
        if (dest > start) dir = UP;
        else if (dest < start) dir = DOWN;
        else dir = STOP;
        send_request(dest, waited);
        next_cycle();                  // target pulse seen by the car
        @(negedge clk);
        compare_motion("motion after target", dir, car_motion(car));
        compare_ready("ready while busy", 1'b0, req_ready);
        prev   = start;
        cycles = 0;
        while (!req_ready && cycles < TRIP_LIMIT) begin
            cur = car_floor(car);
            if (cur != prev) begin
                if (dir == UP) step = prev + 4'd1;
                else if (dir == DOWN) step = prev - 4'd1;
                else step = prev;      // no step allowed
                compare_floor("floor step", step, cur);
            end
            compare_motion("motion", (cur == dest) ? STOP : dir, car_motion(car));
            if (car_motion(car) == UP) saw_up = 1'b1;
            if (car_motion(car) == DOWN) saw_down = 1'b1;
            compare_floor("other car", other, car_floor(1 - car));
            prev = cur;
            @(negedge clk);
            cycles++;
        end
        if (!req_ready) flag_error($sformatf("car %0d never returned its credit", car));
        compare_floor("arrival floor", dest, car_floor(car));
        compare_motion("arrival motion", STOP, car_motion(car));
        next_cycle();
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////

    task automatic test_reset_state();
        begin_test("reset_state");
        compare_floor("car 0 floor", CAR0_HOME, car0_floor);
        compare_floor("car 1 floor", CAR1_HOME, car1_floor);
        compare_motion("car 0 motion", STOP, car0_motion);
        compare_motion("car 1 motion", STOP, car1_motion);
        req_floor = 4'd4;
        @(negedge clk);
        compare_ready("even ready", 1'b1, req_ready);
        next_cycle();
        req_floor = 4'd7;
        @(negedge clk);
        compare_ready("odd ready", 1'b1, req_ready);
        compare_seg("car 0 tens", SEG_OFF, car0_seg_tens);
        compare_seg("car 0 ones", DIGIT_SEG[0], car0_seg_ones);
        compare_seg("car 1 tens", SEG_OFF, car1_seg_tens);
        compare_seg("car 1 ones", DIGIT_SEG[1], car1_seg_ones);
        next_cycle();
        end_test();
    endtask

    task automatic test_even_up();
        bit up, down;
        begin_test("even_up");
        trip(0, 4'd6, up, down);
        if (!up || down) flag_error("car 0 did not travel straight up");
        end_test();
    endtask

    task automatic test_odd_both_ways();
        bit up, down;
        begin_test("odd_both_ways");
        trip(1, 4'd9, up, down);
        if (!up) flag_error("car 1 never moved up to floor 9");
        trip(1, 4'd3, up, down);
        if (!down) flag_error("car 1 never moved down to floor 3");
        end_test();
    endtask

    task automatic test_same_floor();
        bit up, down;
        begin_test("same_floor");
        trip(0, car0_floor, up, down); // dwell only
        if (up || down) flag_error("car 0 moved on a request for its own floor");
        end_test();
    endtask

    task automatic test_backpressure();
        int waited, cycles;
        bit both_moving;
        begin_test("backpressure");
        send_request(4'd14, waited);   // car 0 from 6 to 14
        send_request(4'd11, waited);   // car 1 from 3 to 11
        if (waited != 0) flag_error("odd request was held while car 1 was free");
        req_floor   = 4'd2;            // even request held behind car 0
        req_valid   = 1'b1;
        both_moving = 1'b0;
        cycles      = 0;
        @(negedge clk);
        compare_ready("even ready while car 0 busy", 1'b0, req_ready);
        while (!req_ready && cycles < TRIP_LIMIT) begin
            if (car0_motion != STOP && car1_motion != STOP) both_moving = 1'b1;
            @(negedge clk);
            cycles++;
        end
        compare_floor("car 0 first stop", 4'd14, car0_floor);
        next_cycle();                  // held request taken here
        req_valid = 1'b0;
        if (!both_moving) flag_error("cars never moved at the same time");
        wait_ready(4'd11);
        compare_floor("car 1 target", 4'd11, car1_floor);
        wait_ready(4'd2);
        compare_floor("car 0 second stop", 4'd2, car0_floor);
        end_test();
    endtask

    task automatic test_display();
        floor_t f;
        int     car;
        bit     up, down;
        begin_test("display");
        for (int i = 0; i < 8; i++) begin
            rng_state = xorshift32(rng_state);
            if (i < 6) f = rng_state[3:0];
            else f = floor_t'(10 + rng_state % 6); // force two-digit floors
            car = int'(f[0]);
            trip(car, f, up, down);
            compare_seg("tens", (f >= 4'd10) ? DIGIT_SEG[1] : SEG_OFF,
                        car ? car1_seg_tens : car0_seg_tens);
            compare_seg("ones", DIGIT_SEG[int'(f) % 10], car ? car1_seg_ones : car0_seg_ones);
        end
        end_test();
    endtask

    ////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////

    initial begin
        reset     = 1'b1;
        req_valid = 1'b0;
        req_floor = '0;
        repeat (16) @(posedge clk);
        #2 reset = 1'b0;
        next_cycle();
        test_reset_state();
        test_even_up();
        test_odd_both_ways();
        test_same_floor();
        test_backpressure();
        test_display();
        $display("tests %0d, failed tests %0d, failed checks %0d",
                 NUM_TESTS, tests_failed, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run still going after %0d cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: elevator.f
rtl/elevator_pkg.sv
rtl/tick_gen.sv
rtl/request_dispatch.sv
rtl/car_controller.sv
rtl/floor_display.sv
rtl/elevator_top.sv
verification/elevator_tb.sv

// File: Makefile
# Verilator build for the two-car elevator controller

TOP := elevator_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f elevator.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f elevator.f --top-module $(TOP) \
		-Mdir obj_dir -o elevator_sim
	./obj_dir/elevator_sim | tee sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
